/* rtl/conv_pkg.sv */
package conv_pkg;

    // pixel and weight are both signed bytes
    localparam int PIX_WIDTH  = 8;
    localparam int ACC_WIDTH  = 32;

    // one bit more than a lane sum so two lanes plus bias cannot wrap
    localparam int SUM_WIDTH  = 33;
    localparam int SUM_AWIDTH = 6;

    localparam int IMG_WIDTH  = 16;
    localparam logic [IMG_WIDTH-1:0] IMG_MAX = 16'h7fff;
    localparam logic [IMG_WIDTH-1:0] IMG_MIN = 16'h8000;

    localparam int WORD_WIDTH = 32;

    typedef struct packed {
        logic [PIX_WIDTH-1:0] pixel_a;
        logic [PIX_WIDTH-1:0] weight_a;
        logic [PIX_WIDTH-1:0] pixel_b;
        logic [PIX_WIDTH-1:0] weight_b;
    } tap_fields_t;

    typedef struct packed {
        logic [7:0]         reserved;
        logic [7:0]         shift;
        logic signed [15:0] bias;
    } cfg_fields_t;

    // the same host word read either as a tap or as a configuration word
    typedef union packed {
        tap_fields_t tap;
        cfg_fields_t cfg;
    } in_word_u;

endpackage

/* rtl/tap_sequencer.sv */
`timescale 1ns/1ps

module tap_sequencer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           in_req,
    input  logic                           in_cfg,
    input  logic                           in_last,
    input  logic [conv_pkg::WORD_WIDTH-1:0] in_word,
    output logic                           in_ack,
    input  logic                           busy,
    output logic                           tap_en,
    output logic                           frame_start,
    output logic                           frame_end,
    output logic [conv_pkg::PIX_WIDTH-1:0] pixel_a,
    output logic [conv_pkg::PIX_WIDTH-1:0] weight_a,
    output logic [conv_pkg::PIX_WIDTH-1:0] pixel_b,
    output logic [conv_pkg::PIX_WIDTH-1:0] weight_b,
    output logic [7:0]                     shift,
    output logic [15:0]                    bias
);
    import conv_pkg::*;

    in_word_u word;
    logic     word_used;
    logic     first_tap;
    logic     end_pending;
    logic     hold;
    logic     take;
    logic     take_tap;

    assign word = in_word;

    // a last tap waits while the previous result is still on its way out;
    // end_pending covers the few cycles before the combiner raises busy
    assign hold     = !in_cfg && in_last && (busy || end_pending);
    assign take     = in_req && !word_used && !in_ack && !hold;
    assign take_tap = take && !in_cfg;

    // handshake states: idle, word_used (acked), in_ack high (waiting for req low)
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_used   <= 1'b0;
            in_ack      <= 1'b0;
            tap_en      <= 1'b0;
            frame_start <= 1'b0;
            frame_end   <= 1'b0;
            first_tap   <= 1'b1;
            end_pending <= 1'b0;
            shift       <= 8'd0;
            bias        <= 16'd0;
        end else begin
            word_used   <= take;
            tap_en      <= take_tap;
            frame_start <= take_tap && first_tap;
            frame_end   <= take_tap && in_last;

            if (word_used) begin
                in_ack <= 1'b1;
            end else if (in_ack && !in_req) begin
                in_ack <= 1'b0;
            end

            if (take && in_cfg) begin
                shift <= word.cfg.shift;
                bias  <= word.cfg.bias;
            end

            // the tap after a last tap opens a new frame
            if (take_tap) begin
                first_tap <= in_last;
            end

            if (take_tap && in_last) begin
                end_pending <= 1'b1;
            end else if (busy) begin
                end_pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_tap) begin
            pixel_a  <= word.tap.pixel_a;
            weight_a <= word.tap.weight_a;
            pixel_b  <= word.tap.pixel_b;
            weight_b <= word.tap.weight_b;
        end
    end

endmodule

/* rtl/mac_lane.sv */
`timescale 1ns/1ps

module mac_lane (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           tap_en,
    input  logic                           frame_start,
    input  logic                           frame_end,
    input  logic [conv_pkg::PIX_WIDTH-1:0] pixel,
    input  logic [conv_pkg::PIX_WIDTH-1:0] weight,
    output logic [conv_pkg::ACC_WIDTH-1:0] lane_sum,
    output logic                           sum_valid
);
    import conv_pkg::*;

    logic signed [2*PIX_WIDTH-1:0] product;
    logic [ACC_WIDTH-1:0]          product_ext;
    logic [ACC_WIDTH-1:0]          acc;
    logic                          end_seen;

    assign product     = $signed(pixel) * $signed(weight);
    assign product_ext = {{(ACC_WIDTH-2*PIX_WIDTH){product[2*PIX_WIDTH-1]}}, product};

    // the first tap of a frame loads instead of adding
    always_ff @(posedge clk) begin
        if (tap_en) begin
            if (frame_start) begin
                acc <= product_ext;
            end else begin
                acc <= acc + product_ext;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            end_seen  <= 1'b0;
            sum_valid <= 1'b0;
        end else begin
            end_seen  <= tap_en && frame_end;
            sum_valid <= end_seen;
        end
    end

    // lane_sum holds the frame result so acc is free for the next frame
    always_ff @(posedge clk) begin
        if (end_seen) begin
            lane_sum <= acc;
        end
    end

endmodule

/* rtl/rescale.sv */
`timescale 1ns/1ps

module rescale (
    input  logic                           clk,
    input  logic [7:0]                     shift,
    input  logic [conv_pkg::SUM_WIDTH-1:0] up_data,
    output logic [conv_pkg::IMG_WIDTH-1:0] dn_data
);
    import conv_pkg::*;

    logic [SUM_WIDTH-1:0]  up_data_1p;
    logic [SUM_WIDTH-1:0]  shifted_1p;
    logic [SUM_AWIDTH-1:0] overflow_1p;
    logic [IMG_WIDTH-1:0]  low_2p;
    logic                  too_big_2p;
    logic                  too_small_2p;
    logic [IMG_WIDTH-1:0]  clamped_3p;

    // a positive number is too large if any bit from the overflow address up is set
    function automatic logic above_max(
        input logic [SUM_WIDTH-1:0]  number,
        input logic [SUM_AWIDTH-1:0] overflow
    );
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < SUM_WIDTH; i++) begin
            if (number[i] && (i >= overflow)) begin
                hit = 1'b1;
            end
        end
        return hit && !number[SUM_WIDTH-1];
    endfunction

    // a negative number is too small if any bit from the overflow address up is clear
    function automatic logic below_min(
        input logic [SUM_WIDTH-1:0]  number,
        input logic [SUM_AWIDTH-1:0] overflow
    );
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < SUM_WIDTH; i++) begin
            if (!number[i] && (i >= overflow)) begin
                hit = 1'b1;
            end
        end
        return hit && number[SUM_WIDTH-1];
    endfunction

    always_ff @(posedge clk) begin
        up_data_1p <= up_data;
        shifted_1p <= up_data >> shift;
        // bit of up_data that lands in the image sign position
        overflow_1p <= SUM_AWIDTH'(IMG_WIDTH - 1) + shift[SUM_AWIDTH-1:0];
    end

    always_ff @(posedge clk) begin
        too_big_2p   <= above_max(up_data_1p, overflow_1p);
        too_small_2p <= below_min(up_data_1p, overflow_1p);
        low_2p       <= shifted_1p[IMG_WIDTH-1:0];
    end

    always_ff @(posedge clk) begin
        if (too_small_2p) begin
            clamped_3p <= IMG_MIN;
        end else if (too_big_2p) begin
            clamped_3p <= IMG_MAX;
        end else begin
            clamped_3p <= low_2p;
        end
    end

    always_ff @(posedge clk) begin
        dn_data <= clamped_3p;
    end

endmodule

/* rtl/lane_combiner.sv */
`timescale 1ns/1ps

module lane_combiner (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [conv_pkg::ACC_WIDTH-1:0] lane_sum_a,
    input  logic [conv_pkg::ACC_WIDTH-1:0] lane_sum_b,
    input  logic                           sum_valid,
    input  logic [7:0]                     shift,
    input  logic [15:0]                    bias,
    output logic                           busy,
    output logic                           out_req,
    input  logic                           out_ack,
    output logic [conv_pkg::IMG_WIDTH-1:0] out_data
);
    import conv_pkg::*;

    logic [SUM_WIDTH-1:0] ext_a;
    logic [SUM_WIDTH-1:0] ext_b;
    logic [SUM_WIDTH-1:0] ext_bias;
    logic [SUM_WIDTH-1:0] sum_r;
    logic [IMG_WIDTH-1:0] dn_data;
    logic [4:0]           vld_pipe;
    logic                 wait_low;

    assign ext_a    = {{(SUM_WIDTH-ACC_WIDTH){lane_sum_a[ACC_WIDTH-1]}}, lane_sum_a};
    assign ext_b    = {{(SUM_WIDTH-ACC_WIDTH){lane_sum_b[ACC_WIDTH-1]}}, lane_sum_b};
    assign ext_bias = {{(SUM_WIDTH-16){bias[15]}}, bias};

    // sum_r stays put until the next frame, so rescale output is stable while held
    always_ff @(posedge clk) begin
        if (sum_valid) begin
            sum_r <= ext_a + ext_b + ext_bias;
        end
    end

    rescale i_rescale (
        .clk     (clk),
        .shift   (shift),
        .up_data (sum_r),
        .dn_data (dn_data)
    );

    // one add stage plus four rescale stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe <= 5'd0;
        end else begin
            vld_pipe <= {vld_pipe[3:0], sum_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (vld_pipe[4]) begin
            out_data <= dn_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            out_req  <= 1'b0;
            wait_low <= 1'b0;
        end else begin
            if (sum_valid) begin
                busy <= 1'b1;
            end

            if (vld_pipe[4]) begin
                out_req <= 1'b1;
            end else if (out_req && out_ack) begin
                out_req  <= 1'b0;
                wait_low <= 1'b1;
            end else if (wait_low && !out_ack) begin
                // host has closed the handshake, the result slot is free
                wait_low <= 1'b0;
                busy     <= 1'b0;
            end
        end
    end

endmodule

/* rtl/conv_pair_top.sv */
`timescale 1ns/1ps

module conv_pair_top (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            in_req,
    input  logic                            in_cfg,
    input  logic                            in_last,
    input  logic [conv_pkg::WORD_WIDTH-1:0] in_word,
    output logic                            in_ack,
    output logic                            out_req,
    input  logic                            out_ack,
    output logic [conv_pkg::IMG_WIDTH-1:0]  out_data
);
    import conv_pkg::*;

    logic                 tap_en;
    logic                 frame_start;
    logic                 frame_end;
    logic [PIX_WIDTH-1:0] pixel_a;
    logic [PIX_WIDTH-1:0] weight_a;
    logic [PIX_WIDTH-1:0] pixel_b;
    logic [PIX_WIDTH-1:0] weight_b;
    logic [7:0]           shift;
    logic [15:0]          bias;
    logic                 busy;
    logic [ACC_WIDTH-1:0] lane_sum_a;
    logic [ACC_WIDTH-1:0] lane_sum_b;
    logic                 sum_valid;

    tap_sequencer i_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_req      (in_req),
        .in_cfg      (in_cfg),
        .in_last     (in_last),
        .in_word     (in_word),
        .in_ack      (in_ack),
        .busy        (busy),
        .tap_en      (tap_en),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .pixel_a     (pixel_a),
        .weight_a    (weight_a),
        .pixel_b     (pixel_b),
        .weight_b    (weight_b),
        .shift       (shift),
        .bias        (bias)
    );

    mac_lane i_lane_a (
        .clk         (clk),
        .rst_n       (rst_n),
        .tap_en      (tap_en),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .pixel       (pixel_a),
        .weight      (weight_a),
        .lane_sum    (lane_sum_a),
        .sum_valid   (sum_valid)
    );

    // both lanes see the same strobes, so lane a's sum_valid stands for both
    mac_lane i_lane_b (
        .clk         (clk),
        .rst_n       (rst_n),
        .tap_en      (tap_en),
        .frame_start (frame_start),
        .frame_end   (frame_end),
        .pixel       (pixel_b),
        .weight      (weight_b),
        .lane_sum    (lane_sum_b),
        .sum_valid   ()
    );

    lane_combiner i_combiner (
        .clk        (clk),
        .rst_n      (rst_n),
        .lane_sum_a (lane_sum_a),
        .lane_sum_b (lane_sum_b),
        .sum_valid  (sum_valid),
        .shift      (shift),
        .bias       (bias),
        .busy       (busy),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_data   (out_data)
    );

endmodule

/* tests/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
    import conv_pkg::*;

    localparam real CLK_PERIOD_NS   = 4.0;
    localparam int  RESET_CYCLES    = 10;
    localparam int  IDLE_CYCLES     = 20;
    localparam int  MAX_WORDS       = 64;
    localparam int  CYCLES_PER_WORD = 40;
    localparam int  WATCHDOG_MARGIN = 200;
    localparam int  MAX_ACK_DELAY   = 48;
    localparam int  MAX_REQ_GAP     = 4;
    localparam logic [31:0] RNG_SEED = 32'h0bc1_36c8;

    localparam logic [3:0] KIND_CFG  = 4'h0;
    localparam logic [3:0] KIND_TAP  = 4'h1;
    localparam logic [3:0] KIND_LAST = 4'h2;
    localparam logic [3:0] KIND_END  = 4'hf;

    logic                  clk;
    logic                  rst_n;
    logic                  in_req;
    logic                  in_cfg;
    logic                  in_last;
    logic [WORD_WIDTH-1:0] in_word;
    logic                  in_ack;
    logic                  out_req;
    logic                  out_ack;
    logic [IMG_WIDTH-1:0]  out_data;

    // each entry is kind, input word and expected result
    logic [51:0]          vectors [0:MAX_WORDS-1];
    logic [IMG_WIDTH-1:0] expected_q [$];
    logic [31:0]          gap_rng = RNG_SEED;
    int                   num_words = 0;
    int                   frames_sent = 0;
    int                   results_seen = 0;
    logic                 loaded = 1'b0;

    clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) i_clock (.clk(clk));

    conv_pair_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_req   (in_req),
        .in_cfg   (in_cfg),
        .in_last  (in_last),
        .in_word  (in_word),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_data (out_data)
    );

    // each process keeps its own xorshift state
    function automatic logic [31:0] next_random(input logic [31:0] state);
        logic [31:0] s;
        s = state ^ (state << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // pixel times weight for both lanes of one tap word
    function automatic longint tap_sum(input logic [WORD_WIDTH-1:0] word);
        return longint'($signed(word[31:24])) * longint'($signed(word[23:16]))
             + longint'($signed(word[15:8])) * longint'($signed(word[7:0]));
    endfunction

    // floor shift of the biased sum, clamped to the image range
    function automatic logic [IMG_WIDTH-1:0] model_result(
        input longint             frame_sum,
        input logic [7:0]         shift,
        input logic signed [15:0] bias
    );
        longint total;
        total = (frame_sum + longint'(bias)) >>> shift;
        if (total > longint'($signed(IMG_MAX))) begin
            return IMG_MAX;
        end
        if (total < longint'($signed(IMG_MIN))) begin
            return IMG_MIN;
        end
        return total[IMG_WIDTH-1:0];
    endfunction

    task automatic compare_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected) begin
            $display("Fail %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("TEST RESULT: FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic send_word(input logic [3:0] kind, input logic [WORD_WIDTH-1:0] word);
        int gap;
        gap_rng = next_random(gap_rng);
        gap = int'(gap_rng % MAX_REQ_GAP);
        repeat (gap) @(negedge clk);
        in_cfg  = (kind == KIND_CFG);
        in_last = (kind == KIND_LAST);
        in_word = word;
        in_req  = 1'b1;
        do @(negedge clk); while (!in_ack);
        in_req = 1'b0;
        do @(negedge clk); while (in_ack);
    endtask

    initial begin
        logic [3:0]           kind;
        logic [WORD_WIDTH-1:0] word;
        logic [IMG_WIDTH-1:0] file_result;
        longint               frame_sum;
        logic [7:0]           cur_shift;
        logic signed [15:0]   cur_bias;

        rst_n     = 1'b0;
        in_req    = 1'b0;
        in_cfg    = 1'b0;
        in_last   = 1'b0;
        in_word   = '0;
        frame_sum = 0;
        cur_shift = 8'd0;
        cur_bias  = 16'sd0;

        for (int i = 0; i < MAX_WORDS; i++) begin
            vectors[i] = {KIND_END, 32'(i), 16'(i)};
        end
        $readmemh("tests/conv_vectors.txt", vectors);
        while (num_words < MAX_WORDS && vectors[num_words][51:48] != KIND_END) begin
            num_words++;
        end
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            compare_value("out_req", 32'd0, 32'(out_req));
            compare_value("in_ack", 32'd0, 32'(in_ack));
        end

        for (int i = 0; i < num_words; i++) begin
            kind        = vectors[i][51:48];
            word        = vectors[i][47:16];
            file_result = vectors[i][15:0];
            if (kind == KIND_CFG) begin
                // wait until every frame in flight has produced its result
                while (results_seen != frames_sent) @(negedge clk);
                cur_shift = word[23:16];
                cur_bias  = word[15:0];
            end else if (kind == KIND_TAP || kind == KIND_LAST) begin
                frame_sum += tap_sum(word);
                if (kind == KIND_LAST) begin
                    compare_value("vector result",
                                  32'(model_result(frame_sum, cur_shift, cur_bias)),
                                  32'(file_result));
                    expected_q.push_back(file_result);
                    frame_sum = 0;
                    frames_sent++;
                end
            end else begin
                $display("vector %0d has an unknown kind %0h", i, kind);
                $display("TEST RESULT: FAIL");
                $fatal(1, "bad vector file");
            end
            send_word(kind, word);
        end

        while (results_seen != frames_sent) @(negedge clk);
        // a repeated result would raise out_req again here
        repeat (IDLE_CYCLES) @(negedge clk);
        if (!out_req) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("an extra result appeared after the last frame");
            $display("TEST RESULT: FAIL");
            $fatal(1, "extra result");
        end
    end

    // output collector with random out_ack delays
    initial begin
        int          delay;
        logic [31:0] ack_rng;
        ack_rng = RNG_SEED;
        out_ack = 1'b0;
        wait (rst_n === 1'b1);
        forever begin
            do @(negedge clk); while (!out_req);
            ack_rng = next_random(ack_rng);
            delay = int'(ack_rng % MAX_ACK_DELAY);
            repeat (delay) @(negedge clk);
            if (expected_q.size() == 0) begin
                $display("a result arrived that no frame was waiting for");
                $display("TEST RESULT: FAIL");
                $fatal(1, "unexpected result");
            end
            compare_value("out_data", 32'(expected_q.pop_front()), 32'(out_data));
            results_seen++;
            out_ack = 1'b1;
            do @(negedge clk); while (out_req);
            out_ack = 1'b0;
        end
    end

    initial begin
        wait (loaded);
        repeat (num_words * CYCLES_PER_WORD + WATCHDOG_MARGIN) @(posedge clk);
        $display("the run timed out before all results came back");
        $display("TEST RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

/* all.f */
rtl/conv_pkg.sv
rtl/tap_sequencer.sv
rtl/mac_lane.sv
rtl/rescale.sv
rtl/lane_combiner.sv
rtl/conv_pair_top.sv
tests/clock_gen.sv
tests/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_top
RTL_TOP   ?= conv_pair_top
FILELIST  ?= all.f
SRCS      ?= $(shell cat $(FILELIST))
RTL_SRCS  ?= $(filter rtl/%,$(SRCS))
OBJ_DIR   ?= obj_dir
LINT_FLAGS  ?= --lint-only -Wall
BUILD_FLAGS ?= --binary --timing -Wno-fatal

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) $(SRCS)

# the simulator exits non-zero when the testbench stops with $fatal
sim: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* tests/conv_vectors.txt */
// kind _ word _ expected: kind 0 config, 1 tap, 2 last tap, f end of list
// config word is reserved, shift, bias; tap word is pixel_a, weight_a, pixel_b, weight_b
0_00040005_0000
1_0a14fd07_0000
1_6432ced8_0000
2_f9092103_01c3
2_9c030101_ffed
0_0000fed4_0000
1_7f7f7f7f_0000
2_7f7f7f7f_7fff
2_807f807f_8000
2_0a0b0c0d_ffde
0_0002fc18_0000
2_323cec1e_015e
0_00110000_0000
2_807f807f_ffff
1_7f7f7f7f_0000
2_7f7f7f7f_0000
f_00000000_0000
